/* hw/anim_pkg.sv */
package anim_pkg;

  localparam int ROWS          = 64;
  localparam int ROW_ADDR_W    = 6;
  localparam int ROW_W         = 512;
  localparam int BYTES_PER_ROW = 64;

  // Upper bits select the row, lower bits the byte in it.
  localparam int WR_ADDR_W     = 12;

  localparam int TIMER_W       = 24;
  localparam int HOLD_BIT      = 12;  // Hardware build used 22.

  typedef enum logic {
    WAITING   = 1'b0,
    SWITCHING = 1'b1
  } ctrl_state_e;

  // One image row, seen whole for reads and byte by byte for writes.
  typedef union packed {
    logic [ROW_W-1:0]              raw;
    logic [BYTES_PER_ROW-1:0][7:0] bytes;
  } pixel_row_u;

endpackage

/* hw/frame_bus_if.sv */
`timescale 1ns/100ps

interface frame_bus_if;

  logic                            rd;       // One-cycle row read strobe.
  logic [anim_pkg::ROW_ADDR_W-1:0] rd_addr;
  logic                            wr;       // One-cycle byte write strobe.
  logic [anim_pkg::WR_ADDR_W-1:0]  wr_addr;
  logic [7:0]                      wr_data;
  logic [anim_pkg::ROW_W-1:0]      data;
  logic                            charged;  // High for the cycle data is valid.

  modport ram (
    input  rd,
    input  rd_addr,
    input  wr,
    input  wr_addr,
    input  wr_data,
    output data,
    output charged
  );

  modport reader (
    output rd,
    output rd_addr,
    input  data,
    input  charged
  );

  modport writer (
    output wr,
    output wr_addr,
    output wr_data
  );

endinterface

/* hw/frame_ram.sv */
`timescale 1ns/100ps

module frame_ram (
  input logic      clk,
  input logic      rst,
  frame_bus_if.ram bus
);

  anim_pkg::pixel_row_u mem [anim_pkg::ROWS];

  logic                                                rd_q;
  logic [anim_pkg::ROW_ADDR_W-1:0]                     rd_addr_q;
  logic [anim_pkg::ROW_ADDR_W-1:0]                     wr_row;
  logic [anim_pkg::WR_ADDR_W-anim_pkg::ROW_ADDR_W-1:0] wr_byte;

  assign wr_row  = bus.wr_addr[anim_pkg::WR_ADDR_W-1 -: anim_pkg::ROW_ADDR_W];
  assign wr_byte = bus.wr_addr[anim_pkg::WR_ADDR_W-anim_pkg::ROW_ADDR_W-1:0];

  // Only the addressed byte changes, the rest of the row is kept.
  always_ff @(posedge clk) begin
    if (bus.wr) begin
      mem[wr_row].bytes[wr_byte] <= bus.wr_data;
    end
  end

  always_ff @(posedge clk) begin
    rd_addr_q <= bus.rd_addr;
    if (rd_q) begin
      bus.data <= mem[rd_addr_q].raw;  // Same-edge write is not seen yet.
    end
  end

  // Request stage, then the row and its valid pulse one edge later.
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_q        <= 1'b0;
      bus.charged <= 1'b0;
    end else begin
      rd_q        <= bus.rd;
      bus.charged <= rd_q;
    end
  end

endmodule

/* hw/row_select.sv */
`timescale 1ns/100ps

module row_select (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            in_rd,
  input  logic [anim_pkg::ROW_ADDR_W-1:0] in_ADDR,
  input  logic                            frame,
  frame_bus_if.reader                     bus0,
  frame_bus_if.reader                     bus1,
  output logic [anim_pkg::ROW_W-1:0]      out_data,
  output logic                            out_VRAM_SIGNAL
);

  logic tag_q;  // Bank of the read in its request stage.
  logic sel_q;  // Bank of the read whose row is on the output.

  // Only the shown bank sees the strobe, the address goes to both.
  assign bus0.rd      = in_rd & ~frame;
  assign bus1.rd      = in_rd & frame;
  assign bus0.rd_addr = in_ADDR;
  assign bus1.rd_addr = in_ADDR;

  // The tag follows the read down the memory pipeline so a swap
  // in between does not redirect it.
  always_ff @(posedge clk) begin
    if (rst) begin
      tag_q <= 1'b0;
      sel_q <= 1'b0;
    end else begin
      if (in_rd) begin
        tag_q <= frame;
      end
      sel_q <= tag_q;
    end
  end

  assign out_data        = sel_q ? bus1.data : bus0.data;
  assign out_VRAM_SIGNAL = bus0.charged | bus1.charged;

endmodule

/* hw/frame_switch_ctrl.sv */
`timescale 1ns/100ps

module frame_switch_ctrl (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           in_VRAM_AVAILABLE,
  input  logic                           wr,
  input  logic [anim_pkg::WR_ADDR_W-1:0] wr_addr,
  input  logic [7:0]                     wr_data,
  output logic                           frame,
  frame_bus_if.writer                    bus0,
  frame_bus_if.writer                    bus1
);

  logic [anim_pkg::TIMER_W-1:0] timer;
  logic [anim_pkg::TIMER_W-1:0] timer_next;
  anim_pkg::ctrl_state_e        state;
  anim_pkg::ctrl_state_e        state_next;
  logic                         frame_next;
  logic                         hold_done;

  assign hold_done = timer[anim_pkg::HOLD_BIT];

  always_comb begin
    timer_next = timer;
    state_next = state;
    frame_next = frame;
    case (state)
      anim_pkg::WAITING: begin
        if (hold_done) begin
          // Hold has passed, the timer stays put until the host allows a swap.
          if (in_VRAM_AVAILABLE) begin
            timer_next = '0;
            frame_next = ~frame;
            state_next = anim_pkg::SWITCHING;
          end
        end else begin
          timer_next = timer + anim_pkg::TIMER_W'(1);
        end
      end
      anim_pkg::SWITCHING: begin
        timer_next = timer + anim_pkg::TIMER_W'(1);  // Counting starts here.
        state_next = anim_pkg::WAITING;
      end
      default: begin
        timer_next = '0;
        state_next = anim_pkg::WAITING;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      timer <= '0;
      state <= anim_pkg::WAITING;
      frame <= 1'b1;  // Bank 1 is shown first.
    end else begin
      timer <= timer_next;
      state <= state_next;
      frame <= frame_next;
    end
  end

  // Host writes land in the bank that is not shown.
  assign bus0.wr      = wr & frame;
  assign bus1.wr      = wr & ~frame;
  assign bus0.wr_addr = wr_addr;
  assign bus1.wr_addr = wr_addr;
  assign bus0.wr_data = wr_data;
  assign bus1.wr_data = wr_data;

endmodule

/* hw/image_select.sv */
`timescale 1ns/100ps

module image_select (
  input  logic                            clk,
  input  logic                            rst,
  input  logic [anim_pkg::ROW_ADDR_W-1:0] in_ADDR,
  input  logic                            in_rd,
  input  logic                            in_VRAM_AVAILABLE,
  input  logic                            wr,
  input  logic [anim_pkg::WR_ADDR_W-1:0]  wr_addr,
  input  logic [7:0]                      wr_data,
  output logic [anim_pkg::ROW_W-1:0]      out_data,
  output logic                            out_VRAM_SIGNAL,
  output logic                            frame
);

  frame_bus_if bus0 ();  // Bank 0 traffic.
  frame_bus_if bus1 ();  // Bank 1 traffic.

  // Owns the shown-frame bit and the write path.
  frame_switch_ctrl u_frame_switch_ctrl (
    .clk               (clk),
    .rst               (rst),
    .in_VRAM_AVAILABLE (in_VRAM_AVAILABLE),
    .wr                (wr),
    .wr_addr           (wr_addr),
    .wr_data           (wr_data),
    .frame             (frame),
    .bus0              (bus0.writer),
    .bus1              (bus1.writer)
  );

  frame_ram u_frame0 (
    .clk (clk),
    .rst (rst),
    .bus (bus0.ram)
  );

  frame_ram u_frame1 (
    .clk (clk),
    .rst (rst),
    .bus (bus1.ram)
  );

  // Read requests go to the shown image and come back tagged.
  row_select u_row_select (
    .clk             (clk),
    .rst             (rst),
    .in_rd           (in_rd),
    .in_ADDR         (in_ADDR),
    .frame           (frame),
    .bus0            (bus0.reader),
    .bus1            (bus1.reader),
    .out_data        (out_data),
    .out_VRAM_SIGNAL (out_VRAM_SIGNAL)
  );

endmodule

/* verification/tb_checks.svh */
task automatic check_value(input string name, input logic [VAL_W-1:0] got,
                           input logic [VAL_W-1:0] exp);
  if (got !== exp) begin
    $display("Fail at time %0t: %s is %0h, expected %0h", $time, name, got, exp);
    $display("Finished with errors");
    $fatal(1, "Mismatch on %s.", name);
  end
endtask

function automatic logic [7:0] lcg_byte();
  lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
  return lcg_state[23:16];  // Upper bits have the longer period.
endfunction

// Byte b of a row sits in bits 8*b+7 down to 8*b.
function automatic logic [VAL_W-1:0] model_row(input logic bank, input int row);
  logic [VAL_W-1:0] r;
  for (int b = 0; b < anim_pkg::BYTES_PER_ROW; b++) begin
    r[b*8 +: 8] = img[bank][row * anim_pkg::BYTES_PER_ROW + b];
  end
  return r;
endfunction

task automatic check_row(input logic bank, input int row);
  check_value("out_VRAM_SIGNAL", VAL_W'(out_VRAM_SIGNAL), VAL_W'(1'b1));
  check_value("out_data", out_data, model_row(bank, row));
endtask

task automatic load_back_bank();
  logic       bank;
  logic [7:0] value;
  bank = ~model_frame;
  for (int a = 0; a < IMG_BYTES; a++) begin
    value = lcg_byte();
    @(posedge clk);
    wr      <= 1'b1;
    wr_addr <= anim_pkg::WR_ADDR_W'(a);  // Row in the upper bits, byte below.
    wr_data <= value;
    img[bank][a] = value;
  end
  @(posedge clk);
  wr <= 1'b0;
endtask

task automatic write_byte(input int row, input int col, input logic [7:0] value);
  @(posedge clk);
  wr      <= 1'b1;
  wr_addr <= anim_pkg::WR_ADDR_W'(row * anim_pkg::BYTES_PER_ROW + col);
  wr_data <= value;
  img[~model_frame][row * anim_pkg::BYTES_PER_ROW + col] = value;
  @(posedge clk);
  wr <= 1'b0;
endtask

// Lets the hold run out with swaps blocked; frame must not move.
task automatic wait_hold();
  repeat (HOLD_CYCLES + 8) @(posedge clk);
  @(negedge clk);
  check_value("frame", VAL_W'(frame), VAL_W'(model_frame));
endtask

task automatic swap_frame();
  @(posedge clk);
  in_VRAM_AVAILABLE <= 1'b1;
  @(posedge clk);
  @(negedge clk);
  check_value("frame", VAL_W'(frame), VAL_W'(!model_frame));
  model_frame = frame;
  @(posedge clk);
  in_VRAM_AVAILABLE <= 1'b0;
endtask

task automatic read_one(input int row);
  @(posedge clk);
  in_rd   <= 1'b1;
  in_ADDR <= anim_pkg::ROW_ADDR_W'(row);
  @(posedge clk);
  in_rd <= 1'b0;
  @(negedge clk);
  check_value("out_VRAM_SIGNAL", VAL_W'(out_VRAM_SIGNAL), '0);
  @(negedge clk);
  check_row(model_frame, row);
  @(negedge clk);
  check_value("out_VRAM_SIGNAL", VAL_W'(out_VRAM_SIGNAL), '0);
endtask

// Back-to-back reads of every row; each result shows two edges after it is driven.
task automatic read_burst();
  for (int i = 0; i < anim_pkg::ROWS + 2; i++) begin
    @(posedge clk);
    in_rd   <= (i < anim_pkg::ROWS);
    in_ADDR <= anim_pkg::ROW_ADDR_W'(i);
    @(negedge clk);
    if (i >= 2) begin
      check_row(model_frame, i - 2);
    end else begin
      check_value("out_VRAM_SIGNAL", VAL_W'(out_VRAM_SIGNAL), '0);
    end
  end
endtask

task automatic idle_after_reset();
  @(negedge clk);
  check_value("frame", VAL_W'(frame), VAL_W'(1'b1));
  repeat (8) begin
    check_value("out_VRAM_SIGNAL", VAL_W'(out_VRAM_SIGNAL), '0);
    @(negedge clk);
  end
endtask

task automatic load_and_swap();
  load_back_bank();
  wait_hold();
  swap_frame();
  load_back_bank();
  wait_hold();
  swap_frame();
endtask

task automatic byte_merge();
  logic [7:0] old_byte;
  old_byte = img[~model_frame][17 * anim_pkg::BYTES_PER_ROW + 5];
  write_byte(17, 5, ~old_byte);
  wait_hold();
  swap_frame();
  read_one(17);
endtask

task automatic read_across_swap();
  logic old_frame;
  wait_hold();
  old_frame = model_frame;
  @(posedge clk);
  in_VRAM_AVAILABLE <= 1'b1;
  in_rd             <= 1'b1;
  in_ADDR           <= anim_pkg::ROW_ADDR_W'(3);
  @(posedge clk);
  in_VRAM_AVAILABLE <= 1'b0;
  in_ADDR           <= anim_pkg::ROW_ADDR_W'(60);
  @(negedge clk);
  check_value("frame", VAL_W'(frame), VAL_W'(!old_frame));
  model_frame = frame;
  @(posedge clk);
  in_rd <= 1'b0;
  @(negedge clk);
  check_row(old_frame, 3);
  @(negedge clk);
  check_row(~old_frame, 60);
endtask

// The written value differs from the shown byte, so a leak into the shown bank shows up.
task automatic shown_write_blocked();
  logic [7:0] shown_byte;
  shown_byte = img[model_frame][40 * anim_pkg::BYTES_PER_ROW + 9];
  write_byte(40, 9, ~shown_byte);
  read_one(40);
  read_burst();
endtask

/* verification/tb_image_select.sv */
`timescale 1ns/100ps

module tb_image_select;

  localparam int CLK_PERIOD  = 100;
  localparam int VAL_W       = anim_pkg::ROW_W;
  localparam int IMG_BYTES   = anim_pkg::ROWS * anim_pkg::BYTES_PER_ROW;
  localparam int HOLD_CYCLES = 1 << anim_pkg::HOLD_BIT;
  // Six hold periods, two full image loads and room for the reads.
  localparam longint WATCHDOG_CYCLES = 6 * (HOLD_CYCLES + 16) + 2 * IMG_BYTES + 2048;

  logic                            clk;
  logic                            rst;
  logic [anim_pkg::ROW_ADDR_W-1:0] in_ADDR;
  logic                            in_rd;
  logic                            in_VRAM_AVAILABLE;
  logic                            wr;
  logic [anim_pkg::WR_ADDR_W-1:0]  wr_addr;
  logic [7:0]                      wr_data;
  logic [anim_pkg::ROW_W-1:0]      out_data;
  logic                            out_VRAM_SIGNAL;
  logic                            frame;

  logic [7:0]  img [2][IMG_BYTES];  // Byte model of both images, row major.
  logic        model_frame;         // Shown bank as last seen on frame.
  logic [31:0] lcg_state;

  image_select DUT (
    .clk               (clk),
    .rst               (rst),
    .in_ADDR           (in_ADDR),
    .in_rd             (in_rd),
    .in_VRAM_AVAILABLE (in_VRAM_AVAILABLE),
    .wr                (wr),
    .wr_addr           (wr_addr),
    .wr_data           (wr_data),
    .out_data          (out_data),
    .out_VRAM_SIGNAL   (out_VRAM_SIGNAL),
    .frame             (frame)
  );

  `include "tb_checks.svh"

  always #(CLK_PERIOD / 2) clk = ~clk;

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Timeout: the tests did not complete in the expected time.");
    $display("Finished with errors");
    $fatal(1, "Run stopped by the watchdog.");
  end

  initial begin
    clk               = 1'b0;
    rst               = 1'b1;
    in_ADDR           = '0;
    in_rd             = 1'b0;
    in_VRAM_AVAILABLE = 1'b0;
    wr                = 1'b0;
    wr_addr           = '0;
    wr_data           = '0;
    model_frame       = 1'b1;  // Bank 1 is shown out of reset.
    lcg_state         = 32'h978a;
    repeat (16) @(posedge clk);
    rst <= 1'b0;

    idle_after_reset();
    load_and_swap();
    read_burst();
    byte_merge();
    read_across_swap();
    shown_write_blocked();

    $display("Finished with no errors");
    $finish;
  end

endmodule

/* files.f */
+incdir+verification
hw/anim_pkg.sv
hw/frame_bus_if.sv
hw/frame_ram.sv
hw/row_select.sv
hw/frame_switch_ctrl.sv
hw/image_select.sv
verification/tb_image_select.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the image_select testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir

verilator --binary --timing -Wno-fatal --top-module tb_image_select \
  -f files.f --Mdir "$BUILD_DIR" -o tb_image_select
if [ $? -ne 0 ]; then
  echo "Verilator build failed."
  exit 1
fi

"./$BUILD_DIR/tb_image_select" > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "Finished with errors" "$LOG"; then
  echo "Simulation FAILED, see $LOG."
  exit 1
fi
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status."
  exit 1
fi

echo "Simulation passed."
exit 0
